// File: rc_macros.svh
`ifndef RC_MACROS_SVH
`define RC_MACROS_SVH

// input sample width.
`define RC_IN_W 24

// output sample width.
`define RC_OUT_W 24

// gain word width.
`define RC_SCALE_W 24

// right-shift amount width for shifts of 1 to 31.
`define RC_SHIFT_W 5

// power-of-two sample FIFO depth.
`define RC_FIFO_DEPTH 16

// product registers after the multiplier including its own register.
`define RC_RETIME_N 4

`endif

// File: rc_pkg.sv
`default_nettype none

`include "rc_macros.svh"

package rc_pkg;

	// signed sample as it arrives from the source.
	typedef logic signed [`RC_IN_W-1:0] sample_t;

	// signed sample after rescaling and saturation.
	typedef logic signed [`RC_OUT_W-1:0] out_sample_t;

	// signed gain word.
	typedef logic signed [`RC_SCALE_W-1:0] scale_t;

	// unsigned arithmetic right-shift amount.
	typedef logic [`RC_SHIFT_W-1:0] shift_t;

	// full precision product of sample and gain.
	typedef logic signed [`RC_IN_W+`RC_SCALE_W-1:0] product_t;

endpackage

`default_nettype wire

// File: rc_sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "rc_macros.svh"

module rc_sample_fifo (
	input wire clk,
	input wire rst_n,
	input wire rc_pkg::sample_t wr_data,
	input wire wr_en,
	input wire rd_en,
	output rc_pkg::sample_t rd_data,
	output logic rd_vld,
	output logic full
);

	localparam int AW = $clog2(`RC_FIFO_DEPTH);

	rc_pkg::sample_t mem [`RC_FIFO_DEPTH];

	// one extra bit so a full buffer differs from an empty one.
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW-1:0] rd_addr;
	logic rd_taken;
	logic empty;
	logic wr_fire;
	logic rd_fire;

	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// writes into a full buffer are dropped.
	assign wr_fire = wr_en && !full;
	assign rd_fire = rd_en && !empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (wr_fire) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			rd_taken <= 1'b0;
			rd_vld <= 1'b0;
		end else begin
			if (rd_fire) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			rd_taken <= rd_fire;
			rd_vld <= rd_taken;
		end
	end

	// the slot stays intact until the word is registered because a write
	// to it lands on the same edge at the earliest.
	always_ff @(posedge clk) begin
		if (rd_fire) begin
			rd_addr <= rd_ptr[AW-1:0];
		end
		if (rd_taken) begin
			rd_data <= mem[rd_addr];
		end
	end

	property p_no_vld_after_empty_read;
		@(posedge clk) disable iff (!rst_n)
		$past(rd_en && empty, 2) |-> !rd_vld;
	endproperty
	a_no_vld_after_empty_read: assert property (p_no_vld_after_empty_read);

endmodule

`default_nettype wire

// File: rc_scale_hold.sv
`timescale 1ns/1ps
`default_nettype none

`include "rc_macros.svh"

module rc_scale_hold (
	input wire clk,
	input wire rst_n,
	input wire recompute,
	input wire rc_pkg::scale_t scale,
	input wire scale_vld,
	input wire scale_clear,
	input wire rc_pkg::shift_t shift,
	output rc_pkg::scale_t cur_scale,
	output rc_pkg::shift_t cur_shift,
	output logic rd_en
);

	logic available;

	// a new gain beats a clear in the same cycle.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			available <= 1'b0;
		end else if (scale_vld) begin
			available <= 1'b1;
		end else if (scale_clear) begin
			available <= 1'b0;
		end
	end

	// shift is taken with the gain so one stream sees one shift.
	always_ff @(posedge clk) begin
		if (scale_vld) begin
			cur_scale <= scale;
			cur_shift <= shift;
		end
	end

	// bypass keeps the FIFO draining while rescale waits for a gain.
	assign rd_en = recompute ? available : 1'b1;

	// the shift width already caps the top of the range at 31.
	property p_loaded_shift_range;
		@(posedge clk) disable iff (!rst_n)
		scale_vld |=> (cur_shift != '0);
	endproperty
	a_loaded_shift_range: assert property (p_loaded_shift_range);

endmodule

`default_nettype wire

// File: rc_rescale_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "rc_macros.svh"

module rc_rescale_pipe (
	input wire clk,
	input wire rst_n,
	input wire recompute,
	input wire rc_pkg::sample_t fifo_data,
	input wire fifo_rvld,
	input wire rc_pkg::scale_t cur_scale,
	input wire rc_pkg::shift_t cur_shift,
	input wire rc_pkg::sample_t in_data,
	input wire in_vld,
	output rc_pkg::out_sample_t out_data,
	output logic out_vld
);

	localparam int N = `RC_RETIME_N;
	localparam int CNT_W = $clog2(`RC_RETIME_N + 4) + 1;

	// signed output range held at product width.
	localparam rc_pkg::product_t OUT_MAX =
		rc_pkg::product_t'({1'b0, {(`RC_OUT_W-1){1'b1}}});
	localparam rc_pkg::product_t OUT_MIN = -OUT_MAX - 1;

	rc_pkg::product_t rt_data [N];
	logic [N-1:0] rt_vld;

	rc_pkg::product_t sh_data;
	logic sh_round;
	logic sh_vld;

	rc_pkg::product_t rnd_sum;
	rc_pkg::out_sample_t rnd_next;
	rc_pkg::out_sample_t rnd_data;
	logic rnd_vld;

	logic [CNT_W-1:0] inflight;

	// stage 0 is the multiplier register and the rest only retime.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rt_vld <= '0;
		end else begin
			rt_vld <= {rt_vld[N-2:0], fifo_rvld};
		end
	end

	always_ff @(posedge clk) begin
		if (recompute) begin
			rt_data[0] <= fifo_data * cur_scale;
		end else begin
			rt_data[0] <= rc_pkg::product_t'(fifo_data);
		end
		for (int i = 1; i < N; i++) begin
			rt_data[i] <= rt_data[i-1];
		end
	end

	// round bit is the last bit shifted out.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sh_vld <= 1'b0;
		end else begin
			sh_vld <= rt_vld[N-1];
		end
	end

	always_ff @(posedge clk) begin
		if (rt_vld[N-1]) begin
			sh_data <= rt_data[N-1] >>> cur_shift;
			sh_round <= rt_data[N-1][cur_shift - 1'b1];
		end
	end

	// round half up and then clamp.
	always_comb begin
		rnd_sum = sh_data + $signed({1'b0, sh_round});
		if (rnd_sum > OUT_MAX) begin
			rnd_next = OUT_MAX[`RC_OUT_W-1:0];
		end else if (rnd_sum < OUT_MIN) begin
			rnd_next = OUT_MIN[`RC_OUT_W-1:0];
		end else begin
			rnd_next = rnd_sum[`RC_OUT_W-1:0];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rnd_vld <= 1'b0;
		end else begin
			rnd_vld <= sh_vld;
		end
	end

	always_ff @(posedge clk) begin
		rnd_data <= rnd_next;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_vld <= 1'b0;
		end else if (recompute) begin
			out_vld <= rnd_vld;
		end else begin
			out_vld <= in_vld;
		end
	end

	// bypass takes the source sample straight in.
	always_ff @(posedge clk) begin
		if (recompute) begin
			out_data <= rnd_data;
		end else begin
			out_data <= in_data;
		end
	end

	// samples between the FIFO and the output stage.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inflight <= '0;
		end else begin
			inflight <= inflight + CNT_W'(fifo_rvld) - CNT_W'(rnd_vld);
		end
	end

	property p_out_needs_read;
		@(posedge clk) disable iff (!rst_n)
		(recompute && out_vld) |-> ($past(inflight) != '0);
	endproperty
	a_out_needs_read: assert property (p_out_needs_read);

endmodule

`default_nettype wire

// File: rc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rc_macros.svh"

module rc_top (
	input wire clk,
	input wire rst_n,
	input wire recompute,
	input wire rc_pkg::scale_t scale,
	input wire scale_vld,
	input wire scale_clear,
	input wire rc_pkg::shift_t shift,
	input wire rc_pkg::sample_t in_data,
	input wire in_vld,
	output rc_pkg::out_sample_t out_data,
	output logic out_vld,
	output logic error
);

	rc_pkg::sample_t fifo_data;
	logic fifo_rvld;
	logic rd_en;
	rc_pkg::scale_t cur_scale;
	rc_pkg::shift_t cur_shift;

	// every source sample enters the FIFO so full means lost samples.
	rc_sample_fifo fifo_i (
		.clk(clk),
		.rst_n(rst_n),
		.wr_data(in_data),
		.wr_en(in_vld),
		.rd_en(rd_en),
		.rd_data(fifo_data),
		.rd_vld(fifo_rvld),
		.full(error)
	);

	rc_scale_hold hold_i (
		.clk(clk),
		.rst_n(rst_n),
		.recompute(recompute),
		.scale(scale),
		.scale_vld(scale_vld),
		.scale_clear(scale_clear),
		.shift(shift),
		.cur_scale(cur_scale),
		.cur_shift(cur_shift),
		.rd_en(rd_en)
	);

	rc_rescale_pipe pipe_i (
		.clk(clk),
		.rst_n(rst_n),
		.recompute(recompute),
		.fifo_data(fifo_data),
		.fifo_rvld(fifo_rvld),
		.cur_scale(cur_scale),
		.cur_shift(cur_shift),
		.in_data(in_data),
		.in_vld(in_vld),
		.out_data(out_data),
		.out_vld(out_vld)
	);

endmodule

`default_nettype wire

// File: tb_rc_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rc_macros.svh"

module tb_rc_top;

	localparam int PERIOD = 4;
	localparam int N_BYPASS = 32;
	localparam int N_RESCALE = 40;
	localparam int N_STALL = 15;
	localparam int N_SAT = 14;
	localparam int N_OVER = 20;
	localparam int TOTAL_SAMPLES = N_BYPASS + N_RESCALE + N_STALL + N_SAT + N_OVER;
	localparam int TIMEOUT_CYCLES = TOTAL_SAMPLES * 20 + 400;
	// write edge to output edge with the FIFO idle.
	localparam int RESCALE_LAT = 5 + `RC_RETIME_N;

	logic clk;
	logic rst_n;
	logic recompute;
	rc_pkg::scale_t scale;
	logic scale_vld;
	logic scale_clear;
	rc_pkg::shift_t shift;
	rc_pkg::sample_t in_data;
	logic in_vld;
	rc_pkg::out_sample_t out_data;
	logic out_vld;
	logic error;

	int cycle = 0;
	int checks = 0;
	int errors = 0;
	int err_mark = 0;
	int out_count = 0;
	int due;
	rc_pkg::scale_t tb_gain;
	rc_pkg::shift_t tb_shift;
	rc_pkg::out_sample_t exp_word;
	rc_pkg::out_sample_t exp_data_q[$];
	int exp_due_q[$];
	rc_pkg::sample_t held_q[$];

	rc_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.recompute(recompute),
		.scale(scale),
		.scale_vld(scale_vld),
		.scale_clear(scale_clear),
		.shift(shift),
		.in_data(in_data),
		.in_vld(in_vld),
		.out_data(out_data),
		.out_vld(out_vld),
		.error(error)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	// multiply, add half an output step, shift down, then clamp.
	function automatic rc_pkg::out_sample_t rescale_ref(input rc_pkg::sample_t s,
			input rc_pkg::scale_t g, input rc_pkg::shift_t sh);
		longint p;
		longint r;
		longint hi;
		longint lo;
		p = longint'(s) * longint'(g);
		r = (p + (longint'(1) <<< (sh - 1))) >>> sh;
		hi = (longint'(1) <<< (`RC_OUT_W - 1)) - 1;
		lo = -hi - 1;
		if (r > hi) begin
			r = hi;
		end else if (r < lo) begin
			r = lo;
		end
		return rc_pkg::out_sample_t'(r);
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual,
				$time);
		end
	endtask

	task automatic push_expected(input rc_pkg::out_sample_t e, input int due_edge);
		exp_data_q.push_back(e);
		exp_due_q.push_back(due_edge);
	endtask

	task automatic send_sample(input rc_pkg::sample_t d, input bit expect_now);
		int take;
		@(posedge clk);
		in_data <= d;
		in_vld <= 1'b1;
		// the counter lags one edge here so d is taken two counts on.
		take = cycle + 2;
		if (expect_now) begin
			if (recompute) begin
				push_expected(rescale_ref(d, tb_gain, tb_shift), take + RESCALE_LAT);
			end else begin
				push_expected(rc_pkg::out_sample_t'(d), take);
			end
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			in_vld <= 1'b0;
		end
	endtask

	task automatic wait_drain();
		idle(1);
		while (exp_data_q.size() != 0) begin
			@(posedge clk);
		end
		idle(12);
	endtask

	task automatic load_gain(input rc_pkg::scale_t g, input rc_pkg::shift_t s);
		tb_gain = g;
		tb_shift = s;
		@(posedge clk);
		scale <= g;
		shift <= s;
		scale_vld <= 1'b1;
		@(posedge clk);
		scale_vld <= 1'b0;
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		scale_clear <= 1'b1;
		@(posedge clk);
		scale_clear <= 1'b0;
	endtask

	task automatic end_test(input string name);
		$display("test %s done with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// each output word is matched against the oldest expected word.
	always @(negedge clk) begin
		if (rst_n && out_vld) begin
			out_count++;
			if (exp_data_q.size() == 0) begin
				errors++;
				$display("output word 0x%0h at %0t arrived with no sample pending",
					out_data, $time);
			end else begin
				exp_word = exp_data_q.pop_front();
				due = exp_due_q.pop_front();
				check_value("out_data", {exp_word}, {out_data});
				if (due >= 0) begin
					check_value("out_edge", due, cycle);
				end
			end
		end
	end

	initial begin
		rc_pkg::sample_t d;
		rc_pkg::scale_t g;
		rc_pkg::shift_t s;
		int mark;
		void'($urandom(94));
		rst_n = 1'b0;
		recompute = 1'b0;
		scale = '0;
		scale_vld = 1'b0;
		scale_clear = 1'b0;
		shift = '0;
		in_data = '0;
		in_vld = 1'b0;
		tb_gain = '0;
		tb_shift = 5'd1;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("out_vld", 0, out_vld);
		check_value("error", 0, error);
		end_test("reset");

		for (int i = 0; i < N_BYPASS; i++) begin
			send_sample(rc_pkg::sample_t'($urandom), 1'b1);
			if ($urandom % 3 == 0) begin
				idle(1);
			end
		end
		wait_drain();
		end_test("bypass");

		@(posedge clk);
		recompute <= 1'b1;
		g = rc_pkg::scale_t'($urandom);
		s = rc_pkg::shift_t'(1 + $urandom % 31);
		load_gain(g, s);
		for (int i = 0; i < N_RESCALE; i++) begin
			send_sample(rc_pkg::sample_t'($urandom), 1'b1);
			idle($urandom % 4);
		end
		wait_drain();
		end_test("rescale");

		// with no gain held every sample parks in the FIFO.
		pulse_clear();
		mark = out_count;
		for (int i = 0; i < N_STALL; i++) begin
			d = rc_pkg::sample_t'($urandom);
			held_q.push_back(d);
			send_sample(d, 1'b0);
		end
		idle(30);
		check_value("out_count", mark, out_count);
		check_value("error", 0, error);
		g = rc_pkg::scale_t'($urandom);
		s = rc_pkg::shift_t'(1 + $urandom % 31);
		load_gain(g, s);
		while (held_q.size() != 0) begin
			d = held_q.pop_front();
			push_expected(rescale_ref(d, tb_gain, tb_shift), -1);
		end
		wait_drain();
		check_value("out_count", mark + N_STALL, out_count);
		end_test("stall");

		load_gain(24'sh7fffff, 5'd1);
		send_sample(24'sh7fffff, 1'b1);
		send_sample(24'sh800000, 1'b1);
		send_sample(24'sh000001, 1'b1);
		send_sample(24'shffffff, 1'b1);
		wait_drain();
		load_gain(24'sh800000, 5'd2);
		send_sample(24'sh7fffff, 1'b1);
		send_sample(24'sh800000, 1'b1);
		send_sample(24'sh000003, 1'b1);
		wait_drain();
		// halves land on 1.5, -1.5, 0.5 and so on.
		load_gain(24'sh000001, 5'd1);
		send_sample(24'sh000003, 1'b1);
		send_sample(24'shfffffd, 1'b1);
		send_sample(24'sh000001, 1'b1);
		send_sample(24'sh7fffff, 1'b1);
		wait_drain();
		load_gain(24'sh000003, 5'd2);
		send_sample(24'sh000002, 1'b1);
		send_sample(24'shfffffe, 1'b1);
		send_sample(24'sh7fffff, 1'b1);
		wait_drain();
		end_test("saturation");

		pulse_clear();
		mark = out_count;
		for (int i = 0; i < N_OVER; i++) begin
			d = rc_pkg::sample_t'($urandom);
			if (i < `RC_FIFO_DEPTH) begin
				held_q.push_back(d);
			end
			send_sample(d, 1'b0);
			@(negedge clk);
			check_value("error", i >= `RC_FIFO_DEPTH, error);
		end
		idle(1);
		@(negedge clk);
		check_value("error", 1, error);
		g = rc_pkg::scale_t'($urandom);
		s = rc_pkg::shift_t'(1 + $urandom % 31);
		load_gain(g, s);
		while (held_q.size() != 0) begin
			d = held_q.pop_front();
			push_expected(rescale_ref(d, tb_gain, tb_shift), -1);
		end
		wait_drain();
		check_value("error", 0, error);
		check_value("out_count", mark + `RC_FIFO_DEPTH, out_count);
		end_test("overflow");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("run timed out after %0d cycles with %0d output words still pending",
			TIMEOUT_CYCLES, exp_data_q.size());
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
rc_pkg.sv
rc_sample_fifo.sv
rc_scale_hold.sv
rc_rescale_pipe.sv
rc_top.sv
tb_rc_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_rc_top
FILELIST ?= tb.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
LINT_FLAGS ?= -Wall
BUILD_FLAGS ?= --assert -Wno-fatal
FAIL_PATTERN ?= Test FAILED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing $(BUILD_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_PATTERN)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
